// File: spmv_pkg.sv
package spmv_pkg;

    localparam int WORD_WIDTH  = 64;
    localparam int ADDR_WIDTH  = 48;
    localparam int COORD_WIDTH = 32;

    typedef logic [WORD_WIDTH-1:0]  word_t;
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [COORD_WIDTH-1:0] coord_t;
    typedef logic                   stream_tag_t;

    localparam stream_tag_t TAG_IDX = 1'b0; // index code stream
    localparam stream_tag_t TAG_VAL = 1'b1; // value stream

    typedef enum logic [3:0] {
        OP_LD     = 4'd1,
        OP_STEADY = 4'd2,
        OP_STOP   = 4'd3
    } opcode_t;

    typedef enum logic [1:0] {
        REG_IDX_ADDR = 2'd0,
        REG_IDX_END  = 2'd1,
        REG_VAL_ADDR = 2'd2,
        REG_VAL_END  = 2'd3
    } reg_sel_t;

    // command word fields
    localparam int OP_FIELD_LSB  = 0;
    localparam int SEL_FIELD_LSB = 4;
    localparam int ARG_FIELD_LSB = 16;

    localparam int WORD_BYTES = 8;

    // index code format
    localparam int CODE_WIDTH       = 8;
    localparam int CODES_PER_WORD   = 8;
    localparam int CODE_NEWLINE_BIT = 7;
    localparam int CODE_DELTA_WIDTH = 5;

    typedef struct packed {
        addr_t       addr;
        stream_tag_t tag;
    } mem_req_t;

    typedef struct packed {
        stream_tag_t tag;
        word_t       data;
    } mem_rsp_t;

    typedef struct packed {
        coord_t row;
        coord_t col;
    } index_entry_t;

    typedef struct packed {
        coord_t row;
        coord_t col;
        word_t  val;
    } matrix_entry_t;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_STEADY
    } fetch_state_t;

endpackage

// File: word_fifo.sv
`timescale 1ns/100ps

module word_fifo
    import spmv_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  word_t d,
    input  logic  pop,
    output word_t q,
    output logic  valid
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);

    word_t             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              do_pop;

    assign valid  = (count != '0);
    assign q      = mem[rd_ptr];
    assign do_pop = pop && valid;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(do_pop);
        end
    end

endmodule

// File: stream_fetcher.sv
`timescale 1ns/100ps

module stream_fetcher
    import spmv_pkg::*;
#(
    parameter int BUF_DEPTH = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  word_t    op,
    input  logic     op_valid,
    output logic     busy,
    output logic     req_mem_ld,
    output mem_req_t req_mem,
    input  logic     req_mem_stall,
    input  logic     idx_credit,
    input  logic     val_credit
);

    localparam int CRED_W = $clog2(BUF_DEPTH + 1);
    localparam logic [CRED_W-1:0] CRED_FULL = CRED_W'(BUF_DEPTH);
    localparam addr_t STEP      = addr_t'(WORD_BYTES);
    localparam addr_t ALIGN_MSK = ~addr_t'(WORD_BYTES - 1);

    fetch_state_t      state;
    addr_t             idx_addr;
    addr_t             idx_end;
    addr_t             val_addr;
    addr_t             val_end;
    logic [CRED_W-1:0] idx_cred;
    logic [CRED_W-1:0] val_cred;
    stream_tag_t       last_tag;

    opcode_t     opcode;
    reg_sel_t    sel;
    addr_t       arg;
    logic        idx_ok;
    logic        val_ok;
    logic        slot_free;
    logic        issue;
    stream_tag_t pick;
    logic        done;

    assign opcode = opcode_t'(op[OP_FIELD_LSB +: 4]);
    assign sel    = reg_sel_t'(op[SEL_FIELD_LSB +: 2]);
    assign arg    = op[ARG_FIELD_LSB +: $bits(addr_t)];

    assign idx_ok    = (idx_addr != idx_end) && (idx_cred != '0);
    assign val_ok    = (val_addr != val_end) && (val_cred != '0);
    assign slot_free = !req_mem_ld || !req_mem_stall; // stalled request holds
    assign issue     = (state == FETCH_STEADY) && slot_free && (idx_ok || val_ok);
    // alternate when both streams can go
    assign pick = (val_ok && (!idx_ok || last_tag == TAG_IDX)) ? TAG_VAL : TAG_IDX;

    assign done = (idx_addr == idx_end) && (val_addr == val_end) &&
                  (idx_cred == CRED_FULL) && (val_cred == CRED_FULL);

    assign busy = (state == FETCH_STEADY);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= FETCH_IDLE;
            idx_addr <= '0;
            idx_end  <= '0;
            val_addr <= '0;
            val_end  <= '0;
            last_tag <= TAG_VAL;
        end else begin
            if (state == FETCH_STEADY && done)
                state <= FETCH_IDLE;
            if (issue) begin
                last_tag <= pick;
                if (pick == TAG_IDX)
                    idx_addr <= idx_addr + STEP;
                else
                    val_addr <= val_addr + STEP;
            end
            if (op_valid) begin
                case (opcode)
                    OP_LD: begin
                        case (sel)
                            REG_IDX_ADDR: idx_addr <= arg;
                            REG_IDX_END:  idx_end  <= arg;
                            REG_VAL_ADDR: val_addr <= arg;
                            REG_VAL_END:  val_end  <= arg;
                        endcase
                    end
                    OP_STEADY: state <= FETCH_STEADY;
                    OP_STOP:   state <= FETCH_IDLE;
                    default: ;
                endcase
            end
        end
    end

    // per-stream counters are spent on issue and returned on pop
    always_ff @(posedge clk) begin
        if (rst) begin
            idx_cred <= CRED_FULL;
            val_cred <= CRED_FULL;
        end else begin
            idx_cred <= idx_cred - CRED_W'(issue && pick == TAG_IDX) + CRED_W'(idx_credit);
            val_cred <= val_cred - CRED_W'(issue && pick == TAG_VAL) + CRED_W'(val_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            req_mem_ld <= 1'b0;
        else if (slot_free)
            req_mem_ld <= issue;
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            req_mem.tag  <= pick;
            req_mem.addr <= ((pick == TAG_IDX) ? idx_addr : val_addr) & ALIGN_MSK;
        end
    end

endmodule

// File: index_decoder.sv
`timescale 1ns/100ps

module index_decoder
    import spmv_pkg::*;
#(
    parameter int BUF_DEPTH = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         word_push,
    input  word_t        word,
    output logic         word_pop,
    output logic         idx_valid,
    output index_entry_t idx_entry,
    input  logic         idx_take
);

    localparam int IDX_W = $clog2(CODES_PER_WORD);
    localparam logic [IDX_W-1:0] LAST_CODE = IDX_W'(CODES_PER_WORD - 1);

    word_t                       head;
    logic                        head_valid;
    logic [IDX_W-1:0]            code_idx;
    logic [CODE_WIDTH-1:0]       code;
    logic [CODE_DELTA_WIDTH-1:0] delta;
    logic                        newline;
    logic                        step;
    coord_t                      row;
    coord_t                      col;
    coord_t                      next_col;

    word_fifo #(.DEPTH(BUF_DEPTH)) u_word_buf (
        .clk   (clk),
        .rst   (rst),
        .push  (word_push),
        .d     (word),
        .pop   (word_pop),
        .q     (head),
        .valid (head_valid)
    );

    // low byte first
    assign code     = head[code_idx * CODE_WIDTH +: CODE_WIDTH];
    assign newline  = code[CODE_NEWLINE_BIT];
    assign delta    = code[CODE_DELTA_WIDTH-1:0];
    assign next_col = col + coord_t'(delta) + coord_t'(1);

    // pause while a held entry is not taken
    assign step     = head_valid && (!idx_valid || idx_take);
    assign word_pop = step && (code_idx == LAST_CODE);

    // the held entry is the running position itself
    assign idx_entry.row = row;
    assign idx_entry.col = col;

    always_ff @(posedge clk) begin
        if (rst) begin
            code_idx  <= '0;
            row       <= '0;
            col       <= '1;
            idx_valid <= 1'b0;
        end else if (step) begin
            code_idx <= code_idx + 1'b1; // wraps after the last code
            if (newline) begin
                row       <= row + 1'b1;
                col       <= '1;
                idx_valid <= 1'b0;
            end else begin
                col       <= next_col;
                idx_valid <= 1'b1;
            end
        end else if (idx_take) begin
            idx_valid <= 1'b0;
        end
    end

endmodule

// File: entry_combiner.sv
`timescale 1ns/100ps

module entry_combiner
    import spmv_pkg::*;
#(
    parameter int OUT_CREDITS = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          idx_valid,
    input  index_entry_t  idx_entry,
    output logic          idx_take,
    input  logic          val_valid,
    input  word_t         val_word,
    output logic          val_take,
    output logic          out_push,
    output matrix_entry_t out_entry,
    input  logic          out_credit
);

    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    logic [CRED_W-1:0] credits;
    logic              take;

    // both sides move together and only with a credit in hand
    assign take     = idx_valid && val_valid && (credits != '0);
    assign idx_take = take;
    assign val_take = take;

    always_ff @(posedge clk) begin
        if (rst) begin
            credits  <= CRED_W'(OUT_CREDITS);
            out_push <= 1'b0;
        end else begin
            credits  <= credits - CRED_W'(take) + CRED_W'(out_credit);
            out_push <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_entry.row <= idx_entry.row;
            out_entry.col <= idx_entry.col;
            out_entry.val <= val_word;
        end
    end

endmodule

// File: spmv_decoder_top.sv
`timescale 1ns/100ps

module spmv_decoder_top
    import spmv_pkg::*;
#(
    parameter int BUF_DEPTH   = 8,
    parameter int OUT_CREDITS = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  word_t         op,
    input  logic          op_valid,
    output logic          busy,
    output logic          req_mem_ld,
    output mem_req_t      req_mem,
    input  logic          req_mem_stall,
    input  logic          rsp_mem_push,
    input  mem_rsp_t      rsp_mem,
    output logic          out_push,
    output matrix_entry_t out_entry,
    input  logic          out_credit
);

    logic         idx_word_push;
    logic         val_word_push;
    logic         idx_credit;
    logic         idx_valid;
    index_entry_t idx_entry;
    logic         idx_take;
    logic         val_valid;
    word_t        val_word;
    logic         val_take;

    // steer responses by stream tag
    assign idx_word_push = rsp_mem_push && (rsp_mem.tag == TAG_IDX);
    assign val_word_push = rsp_mem_push && (rsp_mem.tag == TAG_VAL);

    stream_fetcher #(.BUF_DEPTH(BUF_DEPTH)) u_fetcher (
        .clk           (clk),
        .rst           (rst),
        .op            (op),
        .op_valid      (op_valid),
        .busy          (busy),
        .req_mem_ld    (req_mem_ld),
        .req_mem       (req_mem),
        .req_mem_stall (req_mem_stall),
        .idx_credit    (idx_credit),
        .val_credit    (val_take)    // every value pop frees a slot
    );

    index_decoder #(.BUF_DEPTH(BUF_DEPTH)) u_index_decoder (
        .clk       (clk),
        .rst       (rst),
        .word_push (idx_word_push),
        .word      (rsp_mem.data),
        .word_pop  (idx_credit),
        .idx_valid (idx_valid),
        .idx_entry (idx_entry),
        .idx_take  (idx_take)
    );

    word_fifo #(.DEPTH(BUF_DEPTH)) u_value_buffer (
        .clk   (clk),
        .rst   (rst),
        .push  (val_word_push),
        .d     (rsp_mem.data),
        .pop   (val_take),
        .q     (val_word),
        .valid (val_valid)
    );

    entry_combiner #(.OUT_CREDITS(OUT_CREDITS)) u_combiner (
        .clk        (clk),
        .rst        (rst),
        .idx_valid  (idx_valid),
        .idx_entry  (idx_entry),
        .idx_take   (idx_take),
        .val_valid  (val_valid),
        .val_word   (val_word),
        .val_take   (val_take),
        .out_push   (out_push),
        .out_entry  (out_entry),
        .out_credit (out_credit)
    );

endmodule

// File: tb_mem_model.sv
`timescale 1ns/100ps

module tb_mem_model
    import spmv_pkg::*;
#(
    parameter int LATENCY = 4,
    parameter int WORDS   = 256
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     req_mem_ld,
    input  mem_req_t req_mem,
    input  logic     req_mem_stall,
    output logic     rsp_mem_push,
    output mem_rsp_t rsp_mem,
    input  logic     wr_en,
    input  addr_t    wr_addr,
    input  word_t    wr_data
);

    localparam int AW = $clog2(WORDS);

    word_t              store [WORDS];
    logic [LATENCY-1:0] pipe_push;
    mem_rsp_t           pipe_rsp [LATENCY];
    logic               accept;

    assign accept       = req_mem_ld && !req_mem_stall;
    assign rsp_mem_push = pipe_push[LATENCY-1];
    assign rsp_mem      = pipe_rsp[LATENCY-1];

    // preload port takes a byte address
    always_ff @(posedge clk) begin
        if (wr_en)
            store[wr_addr[AW+2:3]] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pipe_push <= '0;
        else
            pipe_push <= {pipe_push[LATENCY-2:0], accept};
    end

    // fixed delay line keeps responses in request order
    always_ff @(posedge clk) begin
        pipe_rsp[0].tag  <= req_mem.tag;
        pipe_rsp[0].data <= store[req_mem.addr[AW+2:3]];
        for (int i = 1; i < LATENCY; i++)
            pipe_rsp[i] <= pipe_rsp[i-1];
    end

endmodule

// File: tb_spmv_decoder.sv
`timescale 1ns/100ps

module tb_spmv_decoder;
    import spmv_pkg::*;

    localparam int          BUF_DEPTH   = 8;
    localparam int          OUT_CREDITS = 4;
    localparam int          TIMEOUT     = 2000;
    localparam addr_t       IDX_BASE    = 48'h100;
    localparam addr_t       VAL_BASE    = 48'h400;
    localparam logic [31:0] SEED        = 32'hb61a_a9ab;

    logic          clk = 1'b0;
    logic          rst;
    word_t         op;
    logic          op_valid;
    logic          busy;
    logic          req_mem_ld;
    mem_req_t      req_mem;
    logic          req_mem_stall = 1'b0;
    logic          rsp_mem_push;
    mem_rsp_t      rsp_mem;
    logic          out_push;
    matrix_entry_t out_entry;
    logic          out_credit = 1'b0;
    logic          wr_en;
    addr_t         wr_addr;
    word_t         wr_data;

    logic          credit_hold;
    logic          stall_en;
    logic [31:0]   data_lfsr = SEED;
    logic [31:0]   stall_lfsr = SEED;
    int            errors = 0;
    int            pushes_seen;
    int            credits_returned;
    logic          overflow;
    word_t         idx_q[$];
    word_t         val_q[$];
    matrix_entry_t exp_q[$];
    matrix_entry_t got_q[$];
    addr_t         idx_req_q[$];
    addr_t         val_req_q[$];

    spmv_decoder_top #(.BUF_DEPTH(BUF_DEPTH), .OUT_CREDITS(OUT_CREDITS)) dut (.*);
    tb_mem_model #(.LATENCY(4)) mem (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t random_bits(input int n);
        word_t r;
        int    i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[62:0], data_lfsr[0]}; // one step per bit
            data_lfsr = lfsr_step(data_lfsr);
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // monitor of pushes, accepted requests and credit use
    always @(posedge clk) begin
        if (rst) begin
            pushes_seen = 0;
            overflow    = 1'b0;
            got_q.delete();
            idx_req_q.delete();
            val_req_q.delete();
        end else begin
            if (req_mem_ld && !req_mem_stall) begin
                if (req_mem.tag == TAG_IDX)
                    idx_req_q.push_back(req_mem.addr);
                else
                    val_req_q.push_back(req_mem.addr);
            end
            if (out_push) begin
                got_q.push_back(out_entry);
                pushes_seen++;
                if (pushes_seen - credits_returned > OUT_CREDITS)
                    overflow = 1'b1;
            end
        end
    end

    // credit receiver and random memory stall
    always @(negedge clk) begin
        if (rst) begin
            out_credit       = 1'b0;
            credits_returned = 0;
            req_mem_stall    = 1'b0;
        end else begin
            out_credit = !credit_hold && (credits_returned < pushes_seen);
            if (out_credit)
                credits_returned++;
            if (stall_en) begin
                req_mem_stall = stall_lfsr[0];
                stall_lfsr    = lfsr_step(stall_lfsr);
            end else begin
                req_mem_stall = 1'b0;
            end
        end
    end

    task automatic do_reset();
        @(negedge clk);
        rst         = 1'b1;
        op_valid    = 1'b0;
        credit_hold = 1'b0;
        stall_en    = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic send_cmd(input opcode_t opc, input reg_sel_t sel, input addr_t arg);
        @(negedge clk);
        op = '0;
        op[OP_FIELD_LSB +: 4]   = opc;
        op[SEL_FIELD_LSB +: 2]  = sel;
        op[ARG_FIELD_LSB +: 48] = arg;
        op_valid = 1'b1;
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    task automatic load_regs(input int n_idx, input int n_val);
        send_cmd(OP_LD, REG_IDX_ADDR, IDX_BASE);
        send_cmd(OP_LD, REG_IDX_END, IDX_BASE + addr_t'(n_idx * WORD_BYTES));
        send_cmd(OP_LD, REG_VAL_ADDR, VAL_BASE);
        send_cmd(OP_LD, REG_VAL_END, VAL_BASE + addr_t'(n_val * WORD_BYTES));
    endtask

    task automatic write_words(input addr_t base, input word_t words[$]);
        int i;
        for (i = 0; i < words.size(); i++) begin
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = base + addr_t'(i * WORD_BYTES);
            wr_data = words[i];
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    function automatic int count_entries();
        int n;
        int w;
        int b;
        n = 0;
        for (w = 0; w < idx_q.size(); w++)
            for (b = 0; b < CODES_PER_WORD; b++)
                if (!idx_q[w][b*CODE_WIDTH + CODE_NEWLINE_BIT])
                    n++;
        return n;
    endfunction

    task automatic rand_index_words(input int n, input logic no_newline);
        word_t w;
        repeat (n) begin
            w = random_bits(64);
            if (no_newline)
                w = w & 64'h7f7f_7f7f_7f7f_7f7f;
            idx_q.push_back(w);
        end
    endtask

    task automatic fill_values();
        val_q.delete();
        repeat (count_entries())
            val_q.push_back(random_bits(64));
    endtask

    // reference model walks codes low byte first and pairs each entry with the next value
    task automatic build_expected();
        coord_t                row;
        coord_t                col;
        logic [CODE_WIDTH-1:0] code;
        matrix_entry_t         e;
        int                    vi;
        int                    w;
        int                    b;
        exp_q.delete();
        row = '0;
        col = '1;
        vi  = 0;
        for (w = 0; w < idx_q.size(); w++) begin
            for (b = 0; b < CODES_PER_WORD; b++) begin
                code = idx_q[w][b*CODE_WIDTH +: CODE_WIDTH];
                if (code[CODE_NEWLINE_BIT]) begin
                    row = row + coord_t'(1);
                    col = '1;
                end else begin
                    col   = col + coord_t'(code[CODE_DELTA_WIDTH-1:0]) + coord_t'(1);
                    e.row = row;
                    e.col = col;
                    e.val = val_q[vi];
                    exp_q.push_back(e);
                    vi++;
                end
            end
        end
    endtask

    task automatic wait_for_entries(input int n, output bit ok);
        int t;
        t = 0;
        while (got_q.size() < n && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        ok = (got_q.size() >= n);
        if (!ok) begin
            errors++;
            $display("timeout: only %0d of %0d entries came out", got_q.size(), n);
        end
    endtask

    task automatic wait_idle(output bit ok);
        int t;
        t = 0;
        while (busy && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        ok = !busy;
        if (!ok) begin
            errors++;
            $display("timeout: busy stayed high after the last entry");
        end
    endtask

    task automatic check_requests(input string name, input addr_t q[$], input addr_t base,
                                  input int n);
        int i;
        check({name, " request count"}, 64'(q.size()), 64'(n));
        for (i = 0; i < n && i < q.size(); i++)
            check($sformatf("%s req_mem.addr[%0d]", name, i), 64'(q[i]),
                  64'(base + addr_t'(i * WORD_BYTES)));
    endtask

    task automatic check_results();
        int i;
        check("entry count", 64'(got_q.size()), 64'(exp_q.size()));
        for (i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check($sformatf("out_entry[%0d].row", i), 64'(got_q[i].row), 64'(exp_q[i].row));
            check($sformatf("out_entry[%0d].col", i), 64'(got_q[i].col), 64'(exp_q[i].col));
            check($sformatf("out_entry[%0d].val", i), got_q[i].val, exp_q[i].val);
        end
        check_requests("index", idx_req_q, IDX_BASE, idx_q.size());
        check_requests("value", val_req_q, VAL_BASE, val_q.size());
        check("credit overflow", 64'(overflow), 64'd0);
    endtask

    task automatic run_stream(input int hold_cycles, input logic with_stall);
        bit ok;
        do_reset();
        write_words(IDX_BASE, idx_q);
        write_words(VAL_BASE, val_q);
        build_expected();
        load_regs(idx_q.size(), val_q.size());
        credit_hold = (hold_cycles > 0);
        stall_en    = with_stall;
        send_cmd(OP_STEADY, REG_IDX_ADDR, '0);
        check("busy", 64'(busy), 64'd1);
        if (hold_cycles > 0) begin
            wait_for_entries(OUT_CREDITS, ok);
            repeat (hold_cycles) @(negedge clk);
            check("entries while credits held", 64'(got_q.size()), 64'(OUT_CREDITS));
            credit_hold = 1'b0;
        end
        wait_for_entries(exp_q.size(), ok);
        if (ok)
            wait_idle(ok);
        stall_en = 1'b0;
        repeat (8) @(negedge clk); // catch stray pushes
        check_results();
    endtask

    task automatic test_idle_start();
        do_reset();
        check("busy", 64'(busy), 64'd0);
        check("out_push", 64'(out_push), 64'd0);
        load_regs(0, 0);
        send_cmd(OP_STEADY, REG_IDX_ADDR, '0);
        @(negedge clk);
        check("busy", 64'(busy), 64'd0);
        repeat (10) @(negedge clk);
        check("request count", 64'(idx_req_q.size() + val_req_q.size()), 64'd0);
    endtask

    task automatic test_single_word();
        idx_q.delete();
        idx_q.push_back(64'h1f1e_0a05_0300_0102);
        fill_values();
        run_stream(0, 1'b0);
    endtask

    task automatic test_newlines();
        idx_q.delete();
        idx_q.push_back(64'h0280_0180_8004_0300); // two newlines back to back
        rand_index_words(3, 1'b0);
        fill_values();
        run_stream(0, 1'b0);
    endtask

    task automatic test_backpressure();
        idx_q.delete();
        rand_index_words(3, 1'b1);
        fill_values();
        run_stream(40, 1'b0);
    endtask

    task automatic test_random_stall();
        idx_q.delete();
        rand_index_words(6, 1'b0);
        fill_values();
        run_stream(0, 1'b1);
    endtask

    initial begin
        rst         = 1'b1;
        op          = '0;
        op_valid    = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        credit_hold = 1'b0;
        stall_en    = 1'b0;
        test_idle_start();
        test_single_word();
        test_newlines();
        test_backpressure();
        test_random_stall();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: project.f
spmv_pkg.sv
word_fifo.sv
stream_fetcher.sv
index_decoder.sv
entry_combiner.sv
spmv_decoder_top.sv
tb_mem_model.sv
tb_spmv_decoder.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_spmv_decoder
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
